// ==== activityIndicator.sv ====
// ------------------------------------------------
// slowClock synchronizer and rxIndicator blink FSM
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "sandboxProcess_cfg.svh"

module activityIndicator (
  input  logic masterClock,
  input  logic reset,
  input  logic slowClock,
  input  logic cmdValid,
  output logic rxIndicator
);

  typedef enum logic [2:0] {
    blinkIdle,
    waitRiseOn,
    waitFallOn,
    waitRiseOff,
    waitFallOff
  } blinkState_t;

  blinkState_t                 state;
  logic [`SLOW_SYNC_STAGES-1:0] slowSync;
  logic                        slowPrev;    // for edge detect
  logic                        slowRise;
  logic                        slowFall;

  assign slowRise = slowSync[`SLOW_SYNC_STAGES-1] && !slowPrev;
  assign slowFall = !slowSync[`SLOW_SYNC_STAGES-1] && slowPrev;

  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      slowSync    <= '0;
      slowPrev    <= 1'b0;
      state       <= blinkIdle;
      rxIndicator <= 1'b0;
    end
    else
    begin
      slowSync <= {slowSync[`SLOW_SYNC_STAGES-2:0], slowClock};
      slowPrev <= slowSync[`SLOW_SYNC_STAGES-1];
      case (state)
        blinkIdle:   if (cmdValid) state <= waitRiseOn;   // later pulses ignored
        waitRiseOn:  if (slowRise) state <= waitFallOn;
        waitFallOn:
          if (slowFall)
          begin
            rxIndicator <= 1'b1;
            state       <= waitRiseOff;
          end
        waitRiseOff: if (slowRise) state <= waitFallOff;
        waitFallOff:
          if (slowFall)
          begin
            rxIndicator <= 1'b0;
            state       <= blinkIdle;
          end
        default:
        begin
          rxIndicator <= 1'b0;
          state       <= blinkIdle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== commandDecoder.sv ====
// ------------------------------------------------
// capture stage
// takes one host transfer while the pipeline is idle
// and splits it into store command fields
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "sandboxProcess_cfg.svh"

module commandDecoder (
  input  logic                    masterClock,
  input  logic                    reset,
  input  logic                    dataReceived,
  input  sandboxPkg::hostControl_t control,
  input  sandboxPkg::hostWord_t   inputData,
  input  logic                    busy,
  storeCommandIf.decoder          cmd
);
  import sandboxPkg::*;

  logic accepted;    // transfer taken, busy not yet seen
  logic acceptNow;

  // one transfer per busy window
  assign acceptNow = dataReceived && !busy && !accepted;

  // ------------------------------------------------
  // control state
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      cmd.cmdValid <= 1'b0;
      accepted     <= 1'b0;
    end
    else
    begin
      cmd.cmdValid <= acceptNow;     // single pulse
      if (acceptNow)
        accepted <= 1'b1;
      else if (busy)
        accepted <= 1'b0;            // responder owns it now
    end
  end

  // ------------------------------------------------
  // field split, payload only
  always_ff @(posedge masterClock)
  begin
    if (acceptNow)
    begin
      cmd.request    <= control[0];
      cmd.isMetadata <= control[1];
      cmd.willWrite  <= control[2];
      cmd.index      <= inputData[7:0];
      cmd.value      <= inputData[15:8];
      cmd.meta       <= inputData[23:16];
      // upper selector bits dropped
      cmd.select     <= querySelect_t'(inputData[24 +: `SELECT_WIDTH]);
    end
  end

  // a new command must never overlap one the responder is still serving
  noCmdWhileBusy : assert property (
    @(posedge masterClock) disable iff (!reset)
    cmd.cmdValid |-> !busy
  );

endmodule

`default_nettype wire

// ==== entryStore.sv ====
// ------------------------------------------------
// execute stage
// entry array with value, metadata and valid flag
// stores, reads, value search, metadata count
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "sandboxProcess_cfg.svh"

module entryStore (
  input  logic                   masterClock,
  input  logic                   reset,
  storeCommandIf.store           cmd,
  output logic                   resultValid,
  output logic                   resultBool,
  output sandboxPkg::entryValue_t resultValue,
  output logic                   committed
);
  import sandboxPkg::*;

  localparam int ADDR_W  = $clog2(`ENTRY_COUNT);
  localparam int COUNT_W = $clog2(`ENTRY_COUNT + 1);

  entryValue_t             valueMem [`ENTRY_COUNT];
  entryMeta_t              metaMem  [`ENTRY_COUNT];
  logic [`ENTRY_COUNT-1:0] validFlags;

  logic                    inRange;
  logic [ADDR_W-1:0]       addr;
  logic                    writeHit;
  logic [`ENTRY_COUNT-1:0] valueMatch;   // valid and value equal
  logic [`ENTRY_COUNT-1:0] metaMatch;    // valid and meta equal
  logic                    searchHit;
  entryIndex_t             searchIndex;
  logic [COUNT_W-1:0]      metaCount;
  logic                    queryBool;
  entryValue_t             queryValue;

  assign inRange  = (cmd.index < `ENTRY_COUNT);
  assign addr     = cmd.index[ADDR_W-1:0];
  assign writeHit = cmd.cmdValid && cmd.request && cmd.willWrite && inRange;

  // ------------------------------------------------
  // match flags over the whole array
  always_comb
  begin
    for (int i = 0; i < `ENTRY_COUNT; i++)
    begin
      valueMatch[i] = validFlags[i] && (valueMem[i] == cmd.value);
      metaMatch[i]  = validFlags[i] && (metaMem[i] == cmd.meta);
    end
  end

  // priority scan walking down so the lowest hit wins
  always_comb
  begin
    searchHit   = 1'b0;
    searchIndex = '0;
    for (int i = `ENTRY_COUNT - 1; i >= 0; i--)
    begin
      if (valueMatch[i])
      begin
        searchHit   = 1'b1;
        searchIndex = entryIndex_t'(i);
      end
    end
  end

  // population count of metadata hits
  always_comb
  begin
    metaCount = '0;
    for (int i = 0; i < `ENTRY_COUNT; i++)
      metaCount = metaCount + COUNT_W'(metaMatch[i]);
  end

  // ------------------------------------------------
  // query mux
  always_comb
  begin
    queryBool  = 1'b0;
    queryValue = '0;
    case (cmd.select)
      selReadValue:
        if (inRange && validFlags[addr])
        begin
          queryBool  = 1'b1;
          queryValue = valueMem[addr];
        end
      selReadMeta:
        if (inRange && validFlags[addr])
        begin
          queryBool  = 1'b1;
          queryValue = metaMem[addr];
        end
      selSearchValue:
      begin
        queryBool  = searchHit;
        queryValue = searchIndex;        // zero when no hit
      end
      default:
      begin
        queryBool  = (metaCount != '0);
        queryValue = entryValue_t'(metaCount);
      end
    endcase
  end

  // array writes
  always_ff @(posedge masterClock)
  begin
    if (writeHit)
    begin
      if (cmd.isMetadata)
      begin
        metaMem[addr] <= cmd.meta;
        if (!validFlags[addr])
          valueMem[addr] <= '0;          // first write defines the other byte
      end
      else
      begin
        valueMem[addr] <= cmd.value;
        if (!validFlags[addr])
          metaMem[addr] <= '0;
      end
    end
  end

  // valid flags and result strobe
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      validFlags  <= '0;
      resultValid <= 1'b0;
    end
    else
    begin
      resultValid <= cmd.cmdValid;
      if (writeHit)
        validFlags[addr] <= 1'b1;
    end
  end

  // result payload
  always_ff @(posedge masterClock)
  begin
    if (cmd.cmdValid)
    begin
      resultBool  <= cmd.request ? 1'b1 : queryBool;   // any store reports 1
      resultValue <= cmd.request ? '0 : queryValue;
      committed   <= writeHit;
    end
  end

  // a result is never overlapped by a fresh command
  resultSinglePulse : assert property (
    @(posedge masterClock) disable iff (!reset)
    resultValid |-> !cmd.cmdValid
  );

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
sandboxPkg.sv
storeCommandIf.sv
commandDecoder.sv
entryStore.sv
hostResponder.sv
activityIndicator.sv
sandboxProcess.sv
sandboxProcessTb.sv

// ==== hostResponder.sv ====
// ------------------------------------------------
// respond stage
// latches status and data, drives transmitData,
// clearDR and busy until the host releases
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module hostResponder (
  input  logic                    masterClock,
  input  logic                    reset,
  input  logic                    dataReceived,
  input  logic                    cmdValid,
  input  logic                    resultValid,
  input  logic                    resultBool,
  input  sandboxPkg::entryValue_t resultValue,
  input  logic                    committed,
  output sandboxPkg::statusByte_t status,
  output sandboxPkg::hostWord_t   outputData,
  output logic                    transmitData,
  output logic                    clearDR,
  output logic                    busy
);
  import sandboxPkg::*;

  typedef enum logic [2:0] {
    stIdle,
    stExecute,    // store working
    stPresent,    // result on the outputs
    stSettle,
    stDone,       // clearDR up, waiting for host
    stRelease
  } respState_t;

  respState_t state;

  // ------------------------------------------------
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      state        <= stIdle;
      status       <= '0;
      outputData   <= '0;
      transmitData <= 1'b0;
      clearDR      <= 1'b0;
      busy         <= 1'b0;
    end
    else
    begin
      case (state)
        stIdle:
          if (cmdValid)
          begin
            busy  <= 1'b1;
            state <= stExecute;
          end
        stExecute:
          if (resultValid)
          begin
            status       <= {6'b0, committed, resultBool};
            outputData   <= {24'b0, resultValue};
            transmitData <= 1'b1;                 // ask host to send
            state        <= stPresent;
          end
        stPresent:
          state <= stSettle;
        stSettle:
        begin
          clearDR <= 1'b1;                         // ready for more
          state   <= stDone;
        end
        stDone:
          if (!dataReceived)
          begin
            transmitData <= 1'b0;
            clearDR      <= 1'b0;
            busy         <= 1'b0;
            state        <= stRelease;
          end
        stRelease:
          state <= stIdle;                         // decoder may accept now
        default:
          state <= stIdle;
      endcase
    end
  end

  clearNeedsTransmit : assert property (
    @(posedge masterClock) disable iff (!reset)
    clearDR |-> transmitData
  );

endmodule

`default_nettype wire

// ==== runSim.sh ====
#!/bin/sh
# build the sandbox process testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
  --top-module sandboxProcessTb -o simSandbox \
  || { echo "build failed"; exit 1; }

simOutput="$(./obj_dir/simSandbox)"
printf '%s\n' "$simOutput"

printf '%s\n' "$simOutput" | grep -qx "Testbench passed" \
  && exit 0 \
  || exit 1

// ==== sandboxPkg.sv ====
// ------------------------------------------------
// shared types of the sandbox process
// host transfer vectors, status byte, entry fields
// and the query selector enum
// ------------------------------------------------

`default_nettype none

`include "sandboxProcess_cfg.svh"

package sandboxPkg;

  // host control byte
  // bit 0 request (1 = store), bit 1 isMetadata, bit 2 willWrite
  typedef logic [7:0] hostControl_t;

  // host data word
  // byte 0 index, byte 1 value, byte 2 metadata, byte 3 selector
  typedef logic [31:0] hostWord_t;

  // bit 0 resultBool, bit 1 committed, rest zero
  typedef logic [7:0] statusByte_t;

  typedef logic [7:0] entryIndex_t;   // entry number from the host
  typedef logic [7:0] entryValue_t;   // value byte of one entry
  typedef logic [7:0] entryMeta_t;    // metadata byte of one entry

  // query kinds, taken from the low selector bits
  typedef enum logic [`SELECT_WIDTH-1:0] {
    selReadValue   = 2'd0,
    selReadMeta    = 2'd1,
    selSearchValue = 2'd2,
    selCountMeta   = 2'd3
  } querySelect_t;

endpackage

`default_nettype wire

// ==== sandboxProcess.sv ====
// ------------------------------------------------
// sandbox process top level
// decoder, entry store, responder, rx indicator
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module sandboxProcess (
  input  logic                    masterClock,
  input  logic                    slowClock,     // LED timing
  input  logic                    reset,
  input  logic                    dataReceived,
  input  sandboxPkg::hostControl_t control,
  input  sandboxPkg::hostWord_t   inputData,
  output logic                    clearDR,
  output logic                    transmitData,
  output sandboxPkg::statusByte_t status,
  output sandboxPkg::hostWord_t   outputData,
  output logic                    rxIndicator
);
  import sandboxPkg::*;

  storeCommandIf cmdBus ();

  logic        busy;
  logic        resultValid;
  logic        resultBool;
  entryValue_t resultValue;
  logic        committed;

  // ------------------------------------------------
  commandDecoder i_decoder (
    .masterClock  (masterClock),
    .reset        (reset),
    .dataReceived (dataReceived),
    .control      (control),
    .inputData    (inputData),
    .busy         (busy),
    .cmd          (cmdBus.decoder)
  );

  entryStore i_store (
    .masterClock (masterClock),
    .reset       (reset),
    .cmd         (cmdBus.store),
    .resultValid (resultValid),
    .resultBool  (resultBool),
    .resultValue (resultValue),
    .committed   (committed)
  );

  hostResponder i_responder (
    .masterClock  (masterClock),
    .reset        (reset),
    .dataReceived (dataReceived),
    .cmdValid     (cmdBus.cmdValid),
    .resultValid  (resultValid),
    .resultBool   (resultBool),
    .resultValue  (resultValue),
    .committed    (committed),
    .status       (status),
    .outputData   (outputData),
    .transmitData (transmitData),
    .clearDR      (clearDR),
    .busy         (busy)
  );

  activityIndicator i_indicator (
    .masterClock (masterClock),
    .reset       (reset),
    .slowClock   (slowClock),
    .cmdValid    (cmdBus.cmdValid),
    .rxIndicator (rxIndicator)
  );

endmodule

`default_nettype wire

// ==== sandboxProcessTb.sv ====
// ------------------------------------------------
// testbench for the sandbox process top level
// clocks, reset, the stimulus table with expected
// results, the compare task and bounded waits
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "sandboxProcess_cfg.svh"

module sandboxProcessTb;
  import sandboxPkg::*;

  localparam int resetCycles  = 8;
  localparam int waitLimit    = 40;   // cycles allowed for any single wait
  localparam int sigTransmit  = 0;
  localparam int sigClear     = 1;
  localparam int sigIndicator = 2;

  typedef struct {
    hostControl_t control;
    hostWord_t    data;
    statusByte_t  expStatus;
    hostWord_t    expData;
    int           holdCycles;   // dataReceived kept high past clearDR
  } tableRow_t;

  logic         masterClock;
  logic         slowClock;
  logic         reset;
  logic         dataReceived;
  hostControl_t control;
  hostWord_t    inputData;
  logic         clearDR;
  logic         transmitData;
  statusByte_t  status;
  hostWord_t    outputData;
  logic         rxIndicator;

  tableRow_t rows[$];
  int        errorCount;
  int        checkCount;
  logic      aborted;      // set once a wait runs out

  sandboxProcess i_dut (
    .masterClock  (masterClock),
    .slowClock    (slowClock),
    .reset        (reset),
    .dataReceived (dataReceived),
    .control      (control),
    .inputData    (inputData),
    .clearDR      (clearDR),
    .transmitData (transmitData),
    .status       (status),
    .outputData   (outputData),
    .rxIndicator  (rxIndicator)
  );

  always #50 masterClock = ~masterClock;   // 100 ns period
  always #400 slowClock = ~slowClock;      // flips every 4 master cycles

  // ------------------------------------------------
  // compare and wait helpers
  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  function automatic logic probe(input int sig);
    case (sig)
      sigTransmit: probe = transmitData;
      sigClear:    probe = clearDR;
      default:     probe = rxIndicator;
    endcase
  endfunction

  // bounded wait for one output to reach a level
  task automatic waitLevel(input int sig, input logic level, input string name);
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < waitLimit && !seen && !aborted; n++)
    begin
      @(negedge masterClock);
      seen = (probe(sig) === level);
    end
    if (!seen && !aborted)
    begin
      errorCount++;
      aborted = 1'b1;
      $display("Timeout at %0d ns: %s did not reach %0d within %0d cycles",
               $time, name, level, waitLimit);
    end
  endtask

  task automatic checkQuiet(input string tag);
    checkValue({tag, " transmitData"}, 32'(transmitData), 32'h0);
    checkValue({tag, " clearDR"}, 32'(clearDR), 32'h0);
    checkValue({tag, " rxIndicator"}, 32'(rxIndicator), 32'h0);
    checkValue({tag, " status"}, 32'(status), 32'h0);
    checkValue({tag, " outputData"}, outputData, 32'h0);
  endtask

  // ------------------------------------------------
  // stimulus table
  task automatic addRow(input hostControl_t ctl, input logic [7:0] sel,
                        input entryMeta_t meta, input entryValue_t value,
                        input entryIndex_t index, input statusByte_t expStatus,
                        input entryValue_t expValue, input int hold);
    tableRow_t row;
    row.control    = ctl;
    row.data       = {sel, meta, value, index};   // byte 3 down to byte 0
    row.expStatus  = expStatus;
    row.expData    = {24'h0, expValue};
    row.holdCycles = hold;
    rows.push_back(row);
  endtask

  // control 05 store value, 07 store meta, 01 store without willWrite
  task automatic buildTable();
    addRow(8'h00, 8'h00, 8'h00, 8'h00, 8'd3, 8'h00, 8'h00, 0);  // never written
    addRow(8'h00, 8'h01, 8'h00, 8'h00, 8'd3, 8'h00, 8'h00, 0);
    addRow(8'h05, 8'h00, 8'h00, 8'h5a, 8'd3, 8'h03, 8'h00, 0);
    addRow(8'h07, 8'h00, 8'h21, 8'h00, 8'd3, 8'h03, 8'h00, 0);
    addRow(8'h00, 8'h00, 8'h00, 8'h00, 8'd3, 8'h01, 8'h5a, 0);
    addRow(8'h00, 8'h01, 8'h00, 8'h00, 8'd3, 8'h01, 8'h21, 0);
    addRow(8'h01, 8'h00, 8'h00, 8'h77, 8'd3, 8'h01, 8'h00, 0);  // no willWrite
    addRow(8'h00, 8'h00, 8'h00, 8'h00, 8'd3, 8'h01, 8'h5a, 0);  // value kept
    addRow(8'h01, 8'h00, 8'h00, 8'h66, 8'd5, 8'h01, 8'h00, 0);
    addRow(8'h00, 8'h00, 8'h00, 8'h00, 8'd5, 8'h00, 8'h00, 0);  // still invalid
    addRow(8'h05, 8'h00, 8'h00, 8'h44, 8'(`ENTRY_COUNT + 4), 8'h01, 8'h00, 0);
    addRow(8'h00, 8'h00, 8'h00, 8'h00, 8'(`ENTRY_COUNT + 4), 8'h00, 8'h00, 0);
    addRow(8'h05, 8'h00, 8'h00, 8'h10, 8'(`ENTRY_COUNT), 8'h01, 8'h00, 0);
    addRow(8'h00, 8'h00, 8'h00, 8'h00, 8'd0, 8'h00, 8'h00, 0);  // entry 0 untouched
    addRow(8'h05, 8'h00, 8'h00, 8'h5a, 8'd9, 8'h03, 8'h00, 0);
    addRow(8'h07, 8'h00, 8'h21, 8'h00, 8'd9, 8'h03, 8'h00, 0);
    addRow(8'h05, 8'h00, 8'h00, 8'h5a, 8'd1, 8'h03, 8'h00, 0);
    addRow(8'h00, 8'h02, 8'h00, 8'h5a, 8'd0, 8'h01, 8'h01, 0);  // lowest of 1, 3, 9
    addRow(8'h00, 8'h02, 8'h00, 8'h99, 8'd0, 8'h00, 8'h00, 0);  // no match
    addRow(8'h00, 8'h03, 8'h21, 8'h00, 8'd0, 8'h01, 8'h02, 3);  // entries 3 and 9
    addRow(8'h00, 8'h03, 8'h3c, 8'h00, 8'd0, 8'h00, 8'h00, 0);
    addRow(8'h07, 8'h00, 8'h3c, 8'h00, 8'd15, 8'h03, 8'h00, 6); // long host hold
    addRow(8'h00, 8'h03, 8'h3c, 8'h00, 8'd0, 8'h01, 8'h01, 0);
    addRow(8'h00, 8'hfc, 8'h00, 8'h00, 8'd9, 8'h01, 8'h5a, 0);  // upper select bits
    addRow(8'hf0, 8'h01, 8'h00, 8'h00, 8'd9, 8'h01, 8'h21, 0);  // upper control bits
  endtask

  // ------------------------------------------------
  // one host transfer and its blink
  task automatic transferRow(input tableRow_t row, input string tag);
    waitLevel(sigTransmit, 1'b1, {tag, " transmitData rise"});
    if (!aborted)
    begin
      checkValue({tag, " status"}, 32'(status), 32'(row.expStatus));
      checkValue({tag, " outputData"}, outputData, row.expData);
    end
    waitLevel(sigClear, 1'b1, {tag, " clearDR rise"});
    for (int h = 0; h < row.holdCycles && !aborted; h++)
    begin
      @(negedge masterClock);   // nothing may move while the host holds
      checkValue({tag, " held transmitData"}, 32'(transmitData), 32'h1);
      checkValue({tag, " held clearDR"}, 32'(clearDR), 32'h1);
      checkValue({tag, " held status"}, 32'(status), 32'(row.expStatus));
    end
    @(posedge masterClock);
    dataReceived <= 1'b0;
    waitLevel(sigClear, 1'b0, {tag, " clearDR fall"});
    waitLevel(sigTransmit, 1'b0, {tag, " transmitData fall"});
  endtask

  task automatic watchBlink(input string tag);
    waitLevel(sigIndicator, 1'b1, {tag, " rxIndicator rise"});
    waitLevel(sigIndicator, 1'b0, {tag, " rxIndicator fall"});
  endtask

  task automatic runRow(input tableRow_t row, input int num);
    string tag;
    int    gap;
    tag = $sformatf("row %0d", num);
    gap = int'($urandom % 4);   // random idle time
    repeat (gap) @(posedge masterClock);
    @(posedge masterClock);
    control      <= row.control;
    inputData    <= row.data;
    dataReceived <= 1'b1;
    fork
      transferRow(row, tag);
      watchBlink(tag);
    join
  endtask

  // ------------------------------------------------
  initial
  begin
    masterClock  = 1'b0;
    slowClock    = 1'b0;
    reset        = 1'b0;
    dataReceived = 1'b0;
    control      = '0;
    inputData    = '0;
    errorCount   = 0;
    checkCount   = 0;
    aborted      = 1'b0;
    void'($urandom(65093));
    buildTable();

    repeat (3) @(negedge masterClock);
    checkQuiet("in reset");
    repeat (resetCycles - 3) @(posedge masterClock);
    reset <= 1'b1;
    @(negedge masterClock);
    checkQuiet("after reset");

    foreach (rows[r])
    begin
      if (!aborted)
        runRow(rows[r], r);
    end

    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sandboxProcess_cfg.svh ====
// ------------------------------------------------
// build-time sizing for the sandbox entry store
// entry count, selector code width and the
// slowClock synchronizer depth
// ------------------------------------------------

`ifndef SANDBOX_PROCESS_CFG_SVH
`define SANDBOX_PROCESS_CFG_SVH

// number of entries in the store
// indexes at or above this are out of range
`define ENTRY_COUNT 16

// low bits of the selector byte that pick the query
`define SELECT_WIDTH 2

// flops in the slowClock synchronizer chain
`define SLOW_SYNC_STAGES 2

`endif

// ==== storeCommandIf.sv ====
// ------------------------------------------------
// one decoded host command, decoder to store
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

interface storeCommandIf;
  import sandboxPkg::*;

  logic         cmdValid;    // one-cycle pulse, fields below valid with it
  logic         request;     // 1 = store, 0 = query
  logic         isMetadata;  // store targets the metadata byte
  logic         willWrite;   // store enable
  entryIndex_t  index;
  entryValue_t  value;
  entryMeta_t   meta;
  querySelect_t select;

  // ------------------------------------------------
  modport decoder (
    output cmdValid, request, isMetadata, willWrite,
    output index, value, meta, select
  );

  modport store (
    input cmdValid, request, isMetadata, willWrite,
    input index, value, meta, select
  );

endinterface

`default_nettype wire
